/* score_board_display.f */
+incdir+hdl
hdl/score_board_pkg.sv
hdl/bin_to_bcd.sv
hdl/digit_glyph_rom.sv
hdl/pixel_counter.sv
hdl/draw_fsm.sv
hdl/pixel_writer.sv
hdl/score_board_display.sv
verification/tb_score_board_display.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the score board testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f score_board_display.f \
    --top-module tb_score_board_display \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* verification/score_board_golden.txt */
# glyph <digit> <pattern in hex, bit k is the pixel at column k%4 and row k/4, 1 is ink>
# test <score> <goal> <time> <expected writes> <extra start while painting, 0 or 1>
glyph 0 F999999F
glyph 1 E4444446
glyph 2 F111F88F
glyph 3 F888F88F
glyph 4 8888F999
glyph 5 F888F11F
glyph 6 F999F11F
glyph 7 8888888F
glyph 8 F999F99F
glyph 9 F888F99F
test 7 3 5 96 0
test 1234 4095 60 320 0
test 0 0 9 96 0
test 5 10 42 160 0
test 250 999 30 256 1
test 4000 8 99 224 0

/* verification/tb_score_board_display.sv */
`timescale 1ns/10ps

module tb_score_board_display;

    localparam int TIMEOUT_CYCLES = 3000;
    localparam int GAP_CYCLES     = 30; // long enough for a stray run to show writes
    localparam int ORIGIN_X       = 80;
    localparam int PITCH          = 5;
    localparam int FIELD_ROW [3]  = '{10, 17, 33};
    localparam int FIELD_INK [3]  = '{'hfc3, 'hfff, 'hfff};

    logic        clk;
    logic        resetn;
    logic        start;
    logic [11:0] score;
    logic [11:0] goal;
    logic [11:0] time_left;
    logic [8:0]  out_x;
    logic [7:0]  out_y;
    logic [11:0] color;
    logic        write_en;
    logic        done;

    logic [31:0] glyph [10];
    int          t_score[$];
    int          t_goal[$];
    int          t_time[$];
    int          t_writes[$];
    int          t_extra[$];
    logic [8:0]  exp_x[$];
    logic [7:0]  exp_y[$];
    logic [11:0] exp_c[$];
    int          errors;
    int          passed;
    int          failed;

    score_board_display u_dut (
        .clk(clk), .resetn(resetn), .start(start),
        .score(score), .goal(goal), .time_left(time_left),
        .out_x(out_x), .out_y(out_y), .color(color),
        .write_en(write_en), .done(done)
    );

    always #5 clk = ~clk;

    task automatic read_golden();
        int              fd;
        int              code;
        int              d;
        int              s, g, t, n, x;
        logic [31:0]     pat;
        logic [63:0]     tag;
        logic [8*256-1:0] rest;
        fd = $fopen("verification/score_board_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            tag  = '0;
            code = $fscanf(fd, "%s", tag);
            if (code != 1)
                break;
            if (tag == "#") begin
                code = $fgets(rest, fd); // rest of a comment line
            end else if (tag == "glyph") begin
                code = $fscanf(fd, "%d %h", d, pat);
                if (d >= 0 && d < 10)
                    glyph[d] = pat;
            end else if (tag == "test") begin
                code = $fscanf(fd, "%d %d %d %d %d", s, g, t, n, x);
                t_score.push_back(s);
                t_goal.push_back(g);
                t_time.push_back(t);
                t_writes.push_back(n);
                t_extra.push_back(x);
            end
        end
        $fclose(fd);
    endtask

    function automatic int digit_count(int value, bit is_time);
        if (is_time)
            return (value < 10) ? 1 : 2;
        if (value >= 1000)
            return 4;
        else if (value >= 100)
            return 3;
        else if (value >= 10)
            return 2;
        return 1;
    endfunction

    // writes in paint order: fields score, goal, time, ones digit first
    task automatic build_expected(int s, int g, int t);
        int values [3];
        int f, d, k, nd, dig, scale;
        values = '{s, g, t};
        exp_x.delete();
        exp_y.delete();
        exp_c.delete();
        for (f = 0; f < 3; f++) begin
            nd    = digit_count(values[f], f == 2);
            scale = 1;
            for (d = 0; d < nd; d++) begin
                dig = (values[f] / scale) % 10;
                for (k = 0; k < 32; k++) begin
                    exp_x.push_back(9'(ORIGIN_X - PITCH * d + k % 4));
                    exp_y.push_back(8'(FIELD_ROW[f] + k / 4));
                    exp_c.push_back(glyph[dig][k] ? 12'(FIELD_INK[f]) : 12'h000);
                end
                scale = scale * 10;
            end
        end
    endtask

    task automatic check_write(int w);
        if (w >= exp_x.size()) begin
            $display("unexpected write %0d beyond the end of the golden list", w);
            errors++;
            return;
        end
        assert (out_x == exp_x[w]) else begin
            $display("FAIL out_x write %0d: expected %h, got %h", w, exp_x[w], out_x);
            errors++;
        end
        assert (out_y == exp_y[w]) else begin
            $display("FAIL out_y write %0d: expected %h, got %h", w, exp_y[w], out_y);
            errors++;
        end
        assert (color == exp_c[w]) else begin
            $display("FAIL color write %0d: expected %h, got %h", w, exp_c[w], color);
            errors++;
        end
    endtask

    task automatic check_idle(int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(posedge clk);
            #1;
            assert (!write_en && !done) else begin
                $display("write_en or done raised while the painter should be idle");
                errors++;
            end
        end
    endtask

    task automatic report(string name, int errs_before);
        if (errors == errs_before) begin
            $display("%s: ok", name);
            passed++;
        end else begin
            $display("%s: %0d errors", name, errors - errs_before);
            failed++;
        end
    endtask

    task automatic run_test(int idx);
        int  errs_before, writes, cycles;
        bit  got_done, prev_we, extra_sent;
        string name;
        errs_before = errors;
        name = $sformatf("test %0d score %0d goal %0d time %0d", idx,
                         t_score[idx], t_goal[idx], t_time[idx]);
        build_expected(t_score[idx], t_goal[idx], t_time[idx]);
        assert (exp_x.size() == t_writes[idx]) else begin
            $display("FAIL write count in golden file: expected %h, derived %h",
                     t_writes[idx], exp_x.size());
            errors++;
        end
        @(posedge clk);
        #1;
        score     = 12'(t_score[idx]);
        goal      = 12'(t_goal[idx]);
        time_left = 12'(t_time[idx]);
        start     = 1'b1;
        writes     = 0;
        cycles     = 0;
        got_done   = 1'b0;
        prev_we    = 1'b0;
        extra_sent = 1'b0;
        while (!got_done && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            cycles++;
            start = 1'b0;
            if (write_en) begin
                check_write(writes);
                writes++;
            end
            if (done) begin
                got_done = 1'b1;
                assert (prev_we) else begin
                    $display("done did not come one cycle after the last write");
                    errors++;
                end
                assert (writes == t_writes[idx]) else begin
                    $display("FAIL write count: expected %h, got %h", t_writes[idx], writes);
                    errors++;
                end
            end
            prev_we = write_en;
            if (t_extra[idx] != 0 && !extra_sent && writes == 40) begin
                start      = 1'b1; // painter is busy, must be ignored
                extra_sent = 1'b1;
            end
        end
        if (!got_done) begin
            $display("timeout, done not seen within %0d cycles", TIMEOUT_CYCLES);
            errors++;
        end
        check_idle(GAP_CYCLES);
        report(name, errs_before);
    endtask

    initial begin
        int errs_before;
        clk       = 1'b0;
        resetn    = 1'b0;
        start     = 1'b0;
        score     = '0;
        goal      = '0;
        time_left = '0;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        read_golden();
        if (t_score.size() == 0) begin
            $display("no tests found in the golden file");
            errors++;
        end
        repeat (16) @(posedge clk);
        #1;
        resetn = 1'b1;

        errs_before = errors;
        check_idle(20);
        report("after reset", errs_before);

        for (int i = 0; i < t_score.size(); i++)
            run_test(i);

        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0 && failed == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* hdl/score_board_display.sv */
`timescale 1ns/10ps

module score_board_display (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    start,
    input  score_board_pkg::value_t score,
    input  score_board_pkg::value_t goal,
    input  score_board_pkg::value_t time_left,
    output score_board_pkg::pix_x_t out_x,
    output score_board_pkg::pix_y_t out_y,
    output score_board_pkg::color_t color,
    output logic                    write_en,
    output logic                    done
);

    score_board_pkg::bcd_t       score_ones, score_tens, score_hundreds, score_thousands;
    score_board_pkg::bcd_t       goal_ones, goal_tens, goal_hundreds, goal_thousands;
    score_board_pkg::bcd_t       time_ones, time_tens, time_hundreds, time_thousands;
    score_board_pkg::bcd_t       glyph_digit;
    score_board_pkg::pixel_idx_t pixel_idx, glyph_pixel;
    score_board_pkg::digit_idx_t digit_idx;
    score_board_pkg::field_t     field;
    logic convert_start, score_done, goal_done, time_done;
    logic clear_pixels, count_pixels, clear_digit, step_digit;
    logic last_pixel, pixel_valid, ink;

    bin_to_bcd u_score_bcd (
        .clk(clk), .resetn(resetn), .convert_start(convert_start), .value(score),
        .ones(score_ones), .tens(score_tens), .hundreds(score_hundreds),
        .thousands(score_thousands), .conv_done(score_done)
    );

    bin_to_bcd u_goal_bcd (
        .clk(clk), .resetn(resetn), .convert_start(convert_start), .value(goal),
        .ones(goal_ones), .tens(goal_tens), .hundreds(goal_hundreds),
        .thousands(goal_thousands), .conv_done(goal_done)
    );

    bin_to_bcd u_time_bcd (
        .clk(clk), .resetn(resetn), .convert_start(convert_start), .value(time_left),
        .ones(time_ones), .tens(time_tens), .hundreds(time_hundreds),
        .thousands(time_thousands), .conv_done(time_done)
    );

    pixel_counter u_pixel_counter (
        .clk(clk), .resetn(resetn), .clear_pixels(clear_pixels),
        .count_pixels(count_pixels), .clear_digit(clear_digit), .step_digit(step_digit),
        .pixel_idx(pixel_idx), .digit_idx(digit_idx), .last_pixel(last_pixel)
    );

    draw_fsm u_draw_fsm (
        .clk(clk), .resetn(resetn), .start(start),
        .score_thousands(score_thousands), .score_hundreds(score_hundreds),
        .score_tens(score_tens), .goal_thousands(goal_thousands),
        .goal_hundreds(goal_hundreds), .goal_tens(goal_tens), .time_tens(time_tens),
        .score_done(score_done), .goal_done(goal_done), .time_done(time_done),
        .digit_idx(digit_idx), .last_pixel(last_pixel), .convert_start(convert_start),
        .clear_pixels(clear_pixels), .count_pixels(count_pixels),
        .clear_digit(clear_digit), .step_digit(step_digit),
        .pixel_valid(pixel_valid), .done(done), .field(field)
    );

    pixel_writer u_pixel_writer (
        .clk(clk), .resetn(resetn), .field(field), .digit_idx(digit_idx),
        .pixel_idx(pixel_idx), .pixel_valid(pixel_valid),
        .score_ones(score_ones), .score_tens(score_tens),
        .score_hundreds(score_hundreds), .score_thousands(score_thousands),
        .goal_ones(goal_ones), .goal_tens(goal_tens),
        .goal_hundreds(goal_hundreds), .goal_thousands(goal_thousands),
        .time_ones(time_ones), .time_tens(time_tens),
        .time_hundreds(time_hundreds), .time_thousands(time_thousands),
        .ink(ink), .glyph_digit(glyph_digit), .glyph_pixel(glyph_pixel),
        .out_x(out_x), .out_y(out_y), .color(color), .write_en(write_en)
    );

    digit_glyph_rom u_glyph_rom (
        .clk(clk), .glyph_digit(glyph_digit), .glyph_pixel(glyph_pixel), .ink(ink)
    );

endmodule

/* hdl/pixel_writer.sv */
`timescale 1ns/10ps
`include "score_board_macros.svh"

module pixel_writer (
    input  logic                        clk,
    input  logic                        resetn,
    input  score_board_pkg::field_t     field,
    input  score_board_pkg::digit_idx_t digit_idx,
    input  score_board_pkg::pixel_idx_t pixel_idx,
    input  logic                        pixel_valid,
    input  score_board_pkg::bcd_t       score_ones,
    input  score_board_pkg::bcd_t       score_tens,
    input  score_board_pkg::bcd_t       score_hundreds,
    input  score_board_pkg::bcd_t       score_thousands,
    input  score_board_pkg::bcd_t       goal_ones,
    input  score_board_pkg::bcd_t       goal_tens,
    input  score_board_pkg::bcd_t       goal_hundreds,
    input  score_board_pkg::bcd_t       goal_thousands,
    input  score_board_pkg::bcd_t       time_ones,
    input  score_board_pkg::bcd_t       time_tens,
    input  score_board_pkg::bcd_t       time_hundreds,
    input  score_board_pkg::bcd_t       time_thousands,
    input  logic                        ink,
    output score_board_pkg::bcd_t       glyph_digit,
    output score_board_pkg::pixel_idx_t glyph_pixel,
    output score_board_pkg::pix_x_t     out_x,
    output score_board_pkg::pix_y_t     out_y,
    output score_board_pkg::color_t     color,
    output logic                        write_en
);

    logic [15:0]             field_digits;
    score_board_pkg::pix_x_t s1_x;
    score_board_pkg::pix_y_t s1_y;
    score_board_pkg::color_t s1_ink;
    score_board_pkg::field_t s1_field;
    score_board_pkg::field_t out_field;
    logic                    s1_valid;

    function automatic score_board_pkg::pix_y_t field_row(score_board_pkg::field_t f);
        case (f)
            score_board_pkg::FIELD_SCORE: return `SB_SCORE_Y;
            score_board_pkg::FIELD_GOAL:  return `SB_GOAL_Y;
            default:                      return `SB_TIME_Y;
        endcase
    endfunction

    function automatic score_board_pkg::color_t field_ink(score_board_pkg::field_t f);
        case (f)
            score_board_pkg::FIELD_SCORE: return `SB_SCORE_INK;
            score_board_pkg::FIELD_GOAL:  return `SB_GOAL_INK;
            default:                      return `SB_TIME_INK;
        endcase
    endfunction

    always_comb begin
        case (field)
            score_board_pkg::FIELD_SCORE:
                field_digits = {score_thousands, score_hundreds, score_tens, score_ones};
            score_board_pkg::FIELD_GOAL:
                field_digits = {goal_thousands, goal_hundreds, goal_tens, goal_ones};
            default:
                field_digits = {time_thousands, time_hundreds, time_tens, time_ones};
        endcase
    end

    assign glyph_digit = field_digits[4*digit_idx +: 4];
    assign glyph_pixel = pixel_idx;

    // stage 1, in step with the glyph rom read
    always_ff @(posedge clk) begin
        s1_x     <= `SB_FIELD_X - 9'(`SB_DIGIT_PITCH * digit_idx)
                    + 9'(pixel_idx % `SB_GLYPH_COLS);
        s1_y     <= field_row(field) + 8'(pixel_idx / `SB_GLYPH_COLS);
        s1_ink   <= field_ink(field);
        s1_field <= field;
    end

    // stage 2
    always_ff @(posedge clk) begin
        out_x     <= s1_x;
        out_y     <= s1_y;
        color     <= ink ? s1_ink : `SB_BACKGROUND;
        out_field <= s1_field;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            s1_valid <= 1'b0;
            write_en <= 1'b0;
        end else begin
            s1_valid <= pixel_valid;
            write_en <= s1_valid;
        end
    end

    a_row_in_field: assert property (@(posedge clk) disable iff (!resetn)
        write_en |-> (out_y >= field_row(out_field))
                     && (out_y < field_row(out_field) + `SB_GLYPH_ROWS));

endmodule

/* hdl/draw_fsm.sv */
`timescale 1ns/10ps

module draw_fsm (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        start,
    input  score_board_pkg::bcd_t       score_thousands,
    input  score_board_pkg::bcd_t       score_hundreds,
    input  score_board_pkg::bcd_t       score_tens,
    input  score_board_pkg::bcd_t       goal_thousands,
    input  score_board_pkg::bcd_t       goal_hundreds,
    input  score_board_pkg::bcd_t       goal_tens,
    input  score_board_pkg::bcd_t       time_tens,
    input  logic                        score_done,
    input  logic                        goal_done,
    input  logic                        time_done,
    input  score_board_pkg::digit_idx_t digit_idx,
    input  logic                        last_pixel,
    output logic                        convert_start,
    output logic                        clear_pixels,
    output logic                        count_pixels,
    output logic                        clear_digit,
    output logic                        step_digit,
    output logic                        pixel_valid,
    output logic                        done,
    output score_board_pkg::field_t     field
);

    score_board_pkg::draw_state_t state;
    score_board_pkg::digit_idx_t  last_digit;

    // highest significant digit position, leading zeros suppressed
    function automatic score_board_pkg::digit_idx_t top_digit(score_board_pkg::bcd_t th,
                                                              score_board_pkg::bcd_t hu,
                                                              score_board_pkg::bcd_t te);
        if (th != 4'd0)
            return 2'd3;
        else if (hu != 4'd0)
            return 2'd2;
        else if (te != 4'd0)
            return 2'd1;
        return 2'd0;
    endfunction

    always_comb begin
        case (field)
            score_board_pkg::FIELD_SCORE:
                last_digit = top_digit(score_thousands, score_hundreds, score_tens);
            score_board_pkg::FIELD_GOAL:
                last_digit = top_digit(goal_thousands, goal_hundreds, goal_tens);
            default:
                last_digit = (time_tens != 4'd0) ? 2'd1 : 2'd0; // time is one or two digits
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= score_board_pkg::ST_IDLE;
            field <= score_board_pkg::FIELD_SCORE;
        end else begin
            case (state)
                score_board_pkg::ST_IDLE: begin
                    field <= score_board_pkg::FIELD_SCORE;
                    if (start)
                        state <= score_board_pkg::ST_CONVERT;
                end
                score_board_pkg::ST_CONVERT:
                    if (score_done && goal_done && time_done)
                        state <= score_board_pkg::ST_FIELD_SETUP;
                score_board_pkg::ST_FIELD_SETUP:
                    state <= score_board_pkg::ST_PAINT;
                score_board_pkg::ST_PAINT:
                    if (last_pixel)
                        state <= score_board_pkg::ST_DIGIT_NEXT;
                score_board_pkg::ST_DIGIT_NEXT:
                    if (digit_idx == last_digit)
                        state <= score_board_pkg::ST_FIELD_NEXT;
                    else
                        state <= score_board_pkg::ST_PAINT;
                score_board_pkg::ST_FIELD_NEXT: begin
                    case (field)
                        score_board_pkg::FIELD_SCORE: field <= score_board_pkg::FIELD_GOAL;
                        default:                      field <= score_board_pkg::FIELD_TIME;
                    endcase
                    if (field == score_board_pkg::FIELD_TIME)
                        state <= score_board_pkg::ST_DONE;
                    else
                        state <= score_board_pkg::ST_FIELD_SETUP;
                end
                default:
                    state <= score_board_pkg::ST_IDLE;
            endcase
        end
    end

    assign convert_start = (state == score_board_pkg::ST_IDLE) && start; // busy starts dropped
    assign clear_pixels  = (state == score_board_pkg::ST_FIELD_SETUP);
    assign clear_digit   = (state == score_board_pkg::ST_FIELD_SETUP);
    assign count_pixels  = (state == score_board_pkg::ST_PAINT);
    assign pixel_valid   = (state == score_board_pkg::ST_PAINT);
    assign step_digit    = (state == score_board_pkg::ST_DIGIT_NEXT) && (digit_idx != last_digit);
    assign done          = (state == score_board_pkg::ST_DONE);

    // counter's end-of-glyph strobe only while painting
    a_count_in_paint: assert property (@(posedge clk) disable iff (!resetn)
        last_pixel |-> state == score_board_pkg::ST_PAINT);

    a_done_pulse: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !done);

endmodule

/* hdl/pixel_counter.sv */
`timescale 1ns/10ps
`include "score_board_macros.svh"

module pixel_counter (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        clear_pixels,
    input  logic                        count_pixels,
    input  logic                        clear_digit,
    input  logic                        step_digit,
    output score_board_pkg::pixel_idx_t pixel_idx,
    output score_board_pkg::digit_idx_t digit_idx,
    output logic                        last_pixel
);

    // wraps to zero after the last pixel of a glyph
    always_ff @(posedge clk) begin
        if (!resetn || clear_pixels)
            pixel_idx <= '0;
        else if (count_pixels)
            pixel_idx <= pixel_idx + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!resetn || clear_digit)
            digit_idx <= '0;
        else if (step_digit)
            digit_idx <= digit_idx + 1'b1;
    end

    assign last_pixel = count_pixels && (pixel_idx == 5'(`SB_GLYPH_PIXELS - 1));

endmodule

/* hdl/digit_glyph_rom.sv */
`timescale 1ns/10ps
`include "score_board_macros.svh"

module digit_glyph_rom (
    input  logic                        clk,
    input  score_board_pkg::bcd_t       glyph_digit,
    input  score_board_pkg::pixel_idx_t glyph_pixel,
    output logic                        ink
);

    logic [`SB_GLYPH_PIXELS-1:0] pattern;

    // one nibble per row, top row in the low nibble, bit 0 is the left column
    always_comb begin
        case (glyph_digit)
            4'd0:    pattern = 32'hF999999F;
            4'd1:    pattern = 32'hE4444446;
            4'd2:    pattern = 32'hF111F88F;
            4'd3:    pattern = 32'hF888F88F;
            4'd4:    pattern = 32'h8888F999;
            4'd5:    pattern = 32'hF888F11F;
            4'd6:    pattern = 32'hF999F11F;
            4'd7:    pattern = 32'h8888888F;
            4'd8:    pattern = 32'hF999F99F;
            4'd9:    pattern = 32'hF888F99F;
            default: pattern = '0; // not a decimal digit
        endcase
    end

    always_ff @(posedge clk) begin
        ink <= pattern[glyph_pixel];
    end

endmodule

/* hdl/bin_to_bcd.sv */
`timescale 1ns/10ps
`include "score_board_macros.svh"

module bin_to_bcd (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    convert_start,
    input  score_board_pkg::value_t value,
    output score_board_pkg::bcd_t   ones,
    output score_board_pkg::bcd_t   tens,
    output score_board_pkg::bcd_t   hundreds,
    output score_board_pkg::bcd_t   thousands,
    output logic                    conv_done
);

    score_board_pkg::value_t bin_sr;
    logic [15:0]             bcd_sr;
    logic [15:0]             bcd_adj;
    logic [3:0]              step;
    logic                    busy;

    // add three to every digit above four before the shift
    always_comb begin
        bcd_adj = bcd_sr;
        for (int i = 0; i < 4; i++) begin
            if (bcd_sr[4*i +: 4] > 4'd4)
                bcd_adj[4*i +: 4] = bcd_sr[4*i +: 4] + 4'd3;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy      <= 1'b0;
            step      <= '0;
            conv_done <= 1'b0;
        end else if (convert_start) begin
            busy      <= 1'b1;
            step      <= '0;
            conv_done <= 1'b0;
        end else if (busy) begin
            step <= step + 1'b1;
            if (step == 4'(`SB_VALUE_W - 1)) begin // last of twelve steps
                busy      <= 1'b0;
                conv_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (convert_start) begin
            bin_sr <= value;
            bcd_sr <= '0;
        end else if (busy) begin
            {bcd_sr, bin_sr} <= {bcd_adj[14:0], bin_sr, 1'b0};
        end
    end

    assign ones      = bcd_sr[3:0];
    assign tens      = bcd_sr[7:4];
    assign hundreds  = bcd_sr[11:8];
    assign thousands = bcd_sr[15:12];

    a_digits_decimal: assert property (@(posedge clk) disable iff (!resetn)
        conv_done |-> (ones <= 4'd9 && tens <= 4'd9 && hundreds <= 4'd9 && thousands <= 4'd9));

endmodule

/* hdl/score_board_pkg.sv */
`include "score_board_macros.svh"

package score_board_pkg;

    typedef logic [`SB_VALUE_W-1:0] value_t;
    typedef logic [3:0]             bcd_t;
    typedef logic [`SB_X_W-1:0]     pix_x_t;
    typedef logic [`SB_Y_W-1:0]     pix_y_t;
    typedef logic [`SB_COLOR_W-1:0] color_t;
    typedef logic [4:0]             pixel_idx_t;
    typedef logic [1:0]             digit_idx_t; // 0 is the ones digit

    typedef enum logic [1:0] {
        FIELD_SCORE,
        FIELD_GOAL,
        FIELD_TIME
    } field_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CONVERT,
        ST_FIELD_SETUP,
        ST_PAINT,
        ST_DIGIT_NEXT,
        ST_FIELD_NEXT,
        ST_DONE
    } draw_state_t;

endpackage

/* hdl/score_board_macros.svh */
`ifndef SCORE_BOARD_MACROS_SVH
`define SCORE_BOARD_MACROS_SVH

`define SB_VALUE_W      12
`define SB_X_W          9
`define SB_Y_W          8
`define SB_COLOR_W      12

`define SB_GLYPH_COLS   4
`define SB_GLYPH_ROWS   8
`define SB_GLYPH_PIXELS 32
`define SB_DIGIT_PITCH  5

// ones digit column, then one row per field
`define SB_FIELD_X      9'd80
`define SB_SCORE_Y      8'd10
`define SB_GOAL_Y       8'd17
`define SB_TIME_Y       8'd33

`define SB_SCORE_INK    12'hfc3 // highlight
`define SB_GOAL_INK     12'hfff
`define SB_TIME_INK     12'hfff
`define SB_BACKGROUND   12'h000

`endif
